// ==== hw/csr_macros.svh ====
// Register width, reset values and mstatus field positions
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Register width of the RV64 core
`define CSR_XLEN 64

// Reset values
`define CSR_MSTATUS_RST 64'h0000_0000_0000_1888
`define CSR_MIE_RST     64'h0000_0000_0000_0888
`define CSR_MIP_RST     64'h0000_0000_0000_0080

// MXL = 2 (64-bit) in bits 63:62, I base ISA in bit 8
`define CSR_MISA_VAL    64'h8000_0000_0000_0100

// mstatus fields
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB  11   // MPP is two bits wide

`endif

// ==== hw/csr_pkg.sv ====
// CSR address, CSR operation and exception cause enums
`include "csr_macros.svh"

package csr_pkg;

  // Implemented machine-mode CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MCYCLE    = 12'hB00,
    CSR_MVENDORID = 12'hF11,  // ID registers, read-only space
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  // Synchronous exception codes written to mcause
  typedef enum logic [`CSR_XLEN-1:0] {
    EXCP_ILLEGAL_INSTR  = `CSR_XLEN'd2,
    EXCP_BREAKPOINT     = `CSR_XLEN'd3,
    EXCP_LOAD_MISALIGN  = `CSR_XLEN'd4,
    EXCP_ECALL_M        = `CSR_XLEN'd11
  } excp_cause_e;

endpackage

// ==== hw/trap_if.sv ====
// Trap interface between the trap unit and the CSR register file
`timescale 1ns/1ps
`include "csr_macros.svh"

interface trap_if (
  input logic clk
);

  // Current state, from the register file
  logic [`CSR_XLEN-1:0] mstatus;
  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mepc;

  // Update request, from the trap unit
  logic                 excp_enter;   // One-cycle strobe
  logic                 excp_exit;    // One-cycle strobe, MRET
  logic [`CSR_XLEN-1:0] new_mstatus;
  logic [`CSR_XLEN-1:0] new_mepc;
  csr_pkg::excp_cause_e new_mcause;
  logic [`CSR_XLEN-1:0] new_mtval;

  modport regfile (
    output mstatus, mtvec, mepc,
    input  excp_enter, excp_exit,
    input  new_mstatus, new_mepc, new_mcause, new_mtval
  );

  modport trap (
    input  clk,
    input  mstatus, mtvec, mepc,
    output excp_enter, excp_exit,
    output new_mstatus, new_mepc, new_mcause, new_mtval
  );

endinterface

// ==== hw/csr_op_unit.sv ====
// CSR operation unit: write data and write request for CSRRW, CSRRS and CSRRC
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_op_unit (
  input  logic                 valid,
  input  csr_pkg::csr_op_e     op,
  input  logic [`CSR_XLEN-1:0] operand,
  input  logic [`CSR_XLEN-1:0] old_data,
  output logic                 wr_req,
  output logic [`CSR_XLEN-1:0] wr_data
);

  logic operand_nz;
  logic op_writes;

  assign operand_nz = |operand;

  // New register value from the op
  always_comb begin
    case (op)
      csr_pkg::CSR_RW: begin
        wr_data = operand;
      end
      csr_pkg::CSR_RS: begin
        wr_data = old_data | operand;   // Set bits
      end
      csr_pkg::CSR_RC: begin
        wr_data = old_data & ~operand;  // Clear bits
      end
      default: begin
        wr_data = old_data;
      end
    endcase
  end

  // Set and clear with a zero mask are pure reads
  always_comb begin
    case (op)
      csr_pkg::CSR_RW: begin
        op_writes = 1'b1;
      end
      csr_pkg::CSR_RS,
      csr_pkg::CSR_RC: begin
        op_writes = operand_nz;
      end
      default: begin
        op_writes = 1'b0;  // Reserved encoding never writes
      end
    endcase
  end

  assign wr_req = valid & op_writes;

endmodule

// ==== hw/csr_regfile.sv ====
// Machine-mode CSR storage, address decode, read mux and illegal access check
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_ena,
  input  logic [11:0]          addr,
  input  logic                 wr_req,
  input  logic [`CSR_XLEN-1:0] wr_data,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 illegal,
  trap_if.regfile              trap
);

  logic [`CSR_XLEN-1:0] mstatus_q;
  logic [`CSR_XLEN-1:0] mie_q;
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mscratch_q;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mcause_q;
  logic [`CSR_XLEN-1:0] mtval_q;
  logic [`CSR_XLEN-1:0] mip_q;
  logic [`CSR_XLEN-1:0] mcycle_q;

  csr_pkg::csr_addr_e   addr_e;
  logic [`CSR_XLEN-1:0] rd_mux;
  logic                 addr_hit;
  logic                 ro_space;
  logic                 trap_act;
  logic                 wr_commit;

  assign addr_e   = csr_pkg::csr_addr_e'(addr);
  assign ro_space = (addr[11:10] == 2'b11);
  assign trap_act = trap.excp_enter | trap.excp_exit;

  // Address decode and read select
  always_comb begin
    rd_mux   = '0;
    addr_hit = 1'b1;
    case (addr_e)
      csr_pkg::CSR_MSTATUS:  rd_mux = mstatus_q;
      csr_pkg::CSR_MISA:     rd_mux = `CSR_MISA_VAL;
      csr_pkg::CSR_MIE:      rd_mux = mie_q;
      csr_pkg::CSR_MTVEC:    rd_mux = mtvec_q;
      csr_pkg::CSR_MSCRATCH: rd_mux = mscratch_q;
      csr_pkg::CSR_MEPC:     rd_mux = mepc_q;
      csr_pkg::CSR_MCAUSE:   rd_mux = mcause_q;
      csr_pkg::CSR_MTVAL:    rd_mux = mtval_q;
      csr_pkg::CSR_MIP:      rd_mux = mip_q;
      csr_pkg::CSR_MCYCLE:   rd_mux = mcycle_q;
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID,
      csr_pkg::CSR_MHARTID: begin
        rd_mux = '0;  // ID registers read as zero
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  assign rd_data = {`CSR_XLEN{rd_ena & ~rst}} & rd_mux;

  // Unimplemented address, or a write into the read-only space
  assign illegal = rd_ena & (~addr_hit | (wr_req & ro_space));

  // Trap updates win over a CSR write in the same cycle
  assign wr_commit = wr_req & ~illegal & ~trap_act;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= `CSR_MSTATUS_RST;
      mie_q      <= `CSR_MIE_RST;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= `CSR_MIP_RST;
      mcycle_q   <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
      if (trap_act) begin
        mstatus_q <= trap.new_mstatus;
        if (trap.excp_enter) begin
          mepc_q   <= trap.new_mepc;
          mcause_q <= trap.new_mcause;
          mtval_q  <= trap.new_mtval;
        end
      end else if (wr_commit) begin
        case (addr_e)
          csr_pkg::CSR_MSTATUS:  mstatus_q  <= wr_data;
          csr_pkg::CSR_MIE:      mie_q      <= wr_data;
          csr_pkg::CSR_MTVEC:    mtvec_q    <= wr_data;
          csr_pkg::CSR_MSCRATCH: mscratch_q <= wr_data;
          csr_pkg::CSR_MEPC:     mepc_q     <= wr_data;
          csr_pkg::CSR_MCAUSE:   mcause_q   <= wr_data;
          csr_pkg::CSR_MTVAL:    mtval_q    <= wr_data;
          csr_pkg::CSR_MIP:      mip_q      <= wr_data;  // Plain storage
          csr_pkg::CSR_MCYCLE:   mcycle_q   <= wr_data;  // Count resumes from here
          default: ;  // misa ignores writes
        endcase
      end
    end
  end

  assign trap.mstatus = mstatus_q;
  assign trap.mtvec   = mtvec_q;
  assign trap.mepc    = mepc_q;

  // Trap unit must never request entry and return together
  a_trap_excl: assert property (@(posedge clk) disable iff (rst)
    !(trap.excp_enter && trap.excp_exit))
    else $error("trap entry and return strobes both high");

  // An illegal access leaves state untouched, mcycle just counts on
  a_illegal_no_commit: assert property (@(posedge clk) disable iff (rst)
    (illegal && !trap_act) |=>
      $stable({mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q, mip_q})
      && (mcycle_q == $past(mcycle_q) + 1'b1))
    else $error("CSR state changed after an illegal access");

endmodule

// ==== hw/trap_unit.sv ====
// Trap entry and MRET register updates and redirect target
`timescale 1ns/1ps
`include "csr_macros.svh"

module trap_unit (
  input  logic                 excp_req,
  input  csr_pkg::excp_cause_e excp_cause,
  input  logic [`CSR_XLEN-1:0] excp_pc,
  input  logic [`CSR_XLEN-1:0] excp_tval,
  input  logic                 mret_req,
  output logic                 trap_redirect,
  output logic [`CSR_XLEN-1:0] trap_pc,
  trap_if.trap                 trap
);

  logic [`CSR_XLEN-1:0] mstatus_nxt;
  logic [`CSR_XLEN-1:0] mtvec_base;
  logic                 mret_act;

  // Exception beats MRET when both arrive together
  assign mret_act = mret_req & ~excp_req;

  // Direct mode only so the mode bits are dropped
  assign mtvec_base = {trap.mtvec[`CSR_XLEN-1:2], 2'b00};

  always_comb begin
    mstatus_nxt = trap.mstatus;
    mstatus_nxt[`CSR_MSTATUS_MPP_LSB +: 2] = 2'b11;  // Machine mode only
    if (excp_req) begin
      // Stack the interrupt enable and disable interrupts
      mstatus_nxt[`CSR_MSTATUS_MPIE_BIT] = trap.mstatus[`CSR_MSTATUS_MIE_BIT];
      mstatus_nxt[`CSR_MSTATUS_MIE_BIT]  = 1'b0;
    end else begin
      // MRET pops the stack
      mstatus_nxt[`CSR_MSTATUS_MIE_BIT]  = trap.mstatus[`CSR_MSTATUS_MPIE_BIT];
      mstatus_nxt[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  assign trap.excp_enter  = excp_req;
  assign trap.excp_exit   = mret_act;
  assign trap.new_mstatus = mstatus_nxt;
  assign trap.new_mepc    = excp_pc;
  assign trap.new_mcause  = excp_cause;
  assign trap.new_mtval   = excp_tval;

  assign trap_redirect = excp_req | mret_req;
  assign trap_pc       = excp_req ? mtvec_base : trap.mepc;

  // Saved return address and vector base must both be word aligned
  a_trap_pc_align: assert property (@(posedge trap.clk)
    trap_redirect |-> (trap_pc[1:0] == 2'b00))
    else $error("misaligned trap target");

endmodule

// ==== hw/csr_top.sv ====
// CSR subsystem top level with the op unit, register file and trap unit
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 csr_valid,
  input  csr_pkg::csr_op_e     csr_op,
  input  logic [11:0]          csr_addr,
  input  logic [`CSR_XLEN-1:0] csr_operand,
  input  logic                 excp_req,
  input  csr_pkg::excp_cause_e excp_cause,
  input  logic [`CSR_XLEN-1:0] excp_pc,
  input  logic [`CSR_XLEN-1:0] excp_tval,
  input  logic                 mret_req,
  output logic [`CSR_XLEN-1:0] csr_rdata,
  output logic                 csr_illegal,
  output logic                 trap_redirect,
  output logic [`CSR_XLEN-1:0] trap_pc
);

  logic                 wr_req;
  logic [`CSR_XLEN-1:0] wr_data;

  trap_if u_trap_if (.clk(clk));

  csr_op_unit u_op_unit (
    .valid    (csr_valid),
    .op       (csr_op),
    .operand  (csr_operand),
    .old_data (csr_rdata),    // Old value feeds RS/RC
    .wr_req   (wr_req),
    .wr_data  (wr_data)
  );

  csr_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rd_ena   (csr_valid),
    .addr     (csr_addr),
    .wr_req   (wr_req),
    .wr_data  (wr_data),
    .rd_data  (csr_rdata),
    .illegal  (csr_illegal),
    .trap     (u_trap_if.regfile)
  );

  trap_unit u_trap_unit (
    .excp_req      (excp_req),
    .excp_cause    (excp_cause),
    .excp_pc       (excp_pc),
    .excp_tval     (excp_tval),
    .mret_req      (mret_req),
    .trap_redirect (trap_redirect),
    .trap_pc       (trap_pc),
    .trap          (u_trap_if.trap)
  );

endmodule

// ==== verif/tb_csr_top.sv ====
// csr_top testbench with golden file replay, random mscratch ops, an MRET check and a timeout
`timescale 1ns/1ps
`include "csr_macros.svh"

module tb_csr_top;

  localparam int REC_WORDS = 11;   // Hex words per golden record
  localparam int MAX_RECS  = 128;
  localparam int RAND_OPS  = 16;
  localparam int MRET_OPS  = 3;

  logic                 clk;
  logic                 rst;
  logic                 csr_valid;
  csr_pkg::csr_op_e     csr_op;
  logic [11:0]          csr_addr;
  logic [`CSR_XLEN-1:0] csr_operand;
  logic                 excp_req;
  csr_pkg::excp_cause_e excp_cause;
  logic [`CSR_XLEN-1:0] excp_pc;
  logic [`CSR_XLEN-1:0] excp_tval;
  logic                 mret_req;
  logic [`CSR_XLEN-1:0] csr_rdata;
  logic                 csr_illegal;
  logic                 trap_redirect;
  logic [`CSR_XLEN-1:0] trap_pc;

  logic [63:0]          golden_mem [0:REC_WORDS*MAX_RECS-1];
  logic [`CSR_XLEN-1:0] scratch_model;  // Expected mscratch during the random phase
  int                   num_recs;
  int                   data_errs;
  int                   flag_errs;
  int                   pc_errs;
  int                   setup_errs;
  int                   cycle_cnt;
  int                   cycle_limit;

  csr_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .csr_valid     (csr_valid),
    .csr_op        (csr_op),
    .csr_addr      (csr_addr),
    .csr_operand   (csr_operand),
    .excp_req      (excp_req),
    .excp_cause    (excp_cause),
    .excp_pc       (excp_pc),
    .excp_tval     (excp_tval),
    .mret_req      (mret_req),
    .csr_rdata     (csr_rdata),
    .csr_illegal   (csr_illegal),
    .trap_redirect (trap_redirect),
    .trap_pc       (trap_pc)
  );

  always #50 clk = ~clk;  // 100 ns period

  // Stop a run that never reaches the summary
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_data(input logic [`CSR_XLEN-1:0] got, input logic [`CSR_XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      data_errs++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input logic [`CSR_XLEN-1:0] got, input logic [`CSR_XLEN-1:0] exp,
                          input string what);
    if (got !== exp) begin
      pc_errs++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_idle();
    csr_valid   <= 1'b0;
    csr_op      <= csr_pkg::CSR_RS;
    csr_addr    <= '0;
    csr_operand <= '0;
    excp_req    <= 1'b0;
    excp_cause  <= csr_pkg::EXCP_ILLEGAL_INSTR;
    excp_pc     <= '0;
    excp_tval   <= '0;
    mret_req    <= 1'b0;
  endtask

  // Kind bit 0 is a CSR access, bit 1 an exception and bit 2 an MRET
  task automatic drive_record(input int idx);
    int         base;
    logic [3:0] kind;
    base = idx * REC_WORDS;
    kind = golden_mem[base][3:0];
    csr_valid   <= kind[0];
    excp_req    <= kind[1];
    mret_req    <= kind[2];
    csr_op      <= csr_pkg::csr_op_e'(golden_mem[base+1][1:0]);
    csr_addr    <= golden_mem[base+2][11:0];
    csr_operand <= golden_mem[base+3];
    excp_cause  <= csr_pkg::excp_cause_e'(golden_mem[base+4]);
    excp_pc     <= golden_mem[base+5];
    excp_tval   <= golden_mem[base+6];
  endtask

  task automatic check_record(input int idx);
    int    base;
    string tag;
    base = idx * REC_WORDS;
    tag  = $sformatf("record %0d", idx);
    check_data(csr_rdata, golden_mem[base+7], {tag, " rdata"});
    check_flag(csr_illegal, golden_mem[base+8][0], {tag, " illegal"});
    check_flag(trap_redirect, golden_mem[base+9][0], {tag, " redirect"});
    if (golden_mem[base+9][0]) begin
      check_pc(trap_pc, golden_mem[base+10], {tag, " trap_pc"});  // Target only on redirect
    end
  endtask

  // Random ops on mscratch starting from the zero left by the golden file
  task automatic run_random_ops();
    csr_pkg::csr_op_e     op;
    logic [`CSR_XLEN-1:0] operand;
    logic [`CSR_XLEN-1:0] exp_old;
    for (int i = 0; i <= RAND_OPS; i++) begin
      if (i == RAND_OPS) begin
        op      = csr_pkg::CSR_RS;  // Final read-back
        operand = '0;
      end else begin
        case ($urandom % 3)
          0: op = csr_pkg::CSR_RW;
          1: op = csr_pkg::CSR_RS;
          default: op = csr_pkg::CSR_RC;
        endcase
        operand = {$urandom, $urandom};
        if ($urandom % 4 == 0) begin
          operand = '0;
        end
      end
      exp_old = scratch_model;
      case (op)
        csr_pkg::CSR_RW: scratch_model = operand;
        csr_pkg::CSR_RS: scratch_model = scratch_model | operand;
        default:         scratch_model = scratch_model & ~operand;
      endcase
      @(posedge clk);
      drive_idle();
      csr_valid   <= 1'b1;
      csr_op      <= op;
      csr_addr    <= csr_pkg::CSR_MSCRATCH;
      csr_operand <= operand;
      @(negedge clk);
      check_data(csr_rdata, exp_old, $sformatf("random op %0d rdata", i));
      check_flag(csr_illegal, 1'b0, $sformatf("random op %0d illegal", i));
      check_flag(trap_redirect, 1'b0, $sformatf("random op %0d redirect", i));
    end
  endtask

  // MRET from MIE set and MPIE clear so that both enable bits have to move
  task automatic run_mret_stack();
    logic [`CSR_XLEN-1:0] exp_status;
    exp_status = 64'h0000_0000_0000_1880;  // MIE from MPIE (0), MPIE 1, MPP 3
    @(posedge clk);
    drive_idle();
    csr_valid   <= 1'b1;
    csr_op      <= csr_pkg::CSR_RW;
    csr_addr    <= csr_pkg::CSR_MSTATUS;
    csr_operand <= 64'h8;
    @(negedge clk);
    check_flag(csr_illegal, 1'b0, "mstatus write before mret illegal");
    @(posedge clk);
    drive_idle();
    mret_req <= 1'b1;
    @(negedge clk);
    check_flag(trap_redirect, 1'b1, "mret redirect");
    @(posedge clk);
    drive_idle();
    csr_valid <= 1'b1;
    csr_addr  <= csr_pkg::CSR_MSTATUS;
    @(negedge clk);
    check_data(csr_rdata, exp_status, "mstatus after mret");
  endtask

  initial begin
    int seed_ret;
    clk           = 1'b0;
    rst           = 1'b1;
    csr_valid     = 1'b0;
    csr_op        = csr_pkg::CSR_RS;
    csr_addr      = '0;
    csr_operand   = '0;
    excp_req      = 1'b0;
    excp_cause    = csr_pkg::EXCP_ILLEGAL_INSTR;
    excp_pc       = '0;
    excp_tval     = '0;
    mret_req      = 1'b0;
    scratch_model = '0;
    data_errs     = 0;
    flag_errs     = 0;
    pc_errs       = 0;
    setup_errs    = 0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    seed_ret      = $urandom(84857);
    $readmemh("verif/csr_golden.txt", golden_mem);
    num_recs = 0;
    while (num_recs < MAX_RECS && golden_mem[num_recs*REC_WORDS][3:0] != 4'hf) begin
      num_recs++;
    end
    if (num_recs == 0) begin
      $display("ERROR: no records read from the golden file");
      setup_errs++;
    end
    cycle_limit = (num_recs + RAND_OPS + 1 + MRET_OPS) * 4 + 50;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < num_recs; r++) begin
      @(posedge clk);
      drive_record(r);
      @(negedge clk);
      check_record(r);
    end
    run_random_ops();
    run_mret_stack();
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    $display("Errors: %0d data, %0d flag, %0d pc, %0d setup", data_errs, flag_errs, pc_errs,
             setup_errs);
    if (data_errs + flag_errs + pc_errs + setup_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verif/csr_golden.txt ====
// kind op addr operand cause pc tval | expected: rdata illegal redirect trap_pc
// kind bits: 1 CSR access, 2 exception, 4 MRET, F ends the list
1 2 300 0                0 0        0        1888             0 0 0
1 2 301 0                0 0        0        8000000000000100 0 0 0
1 2 304 0                0 0        0        888              0 0 0
1 2 305 0                0 0        0        0                0 0 0
1 2 340 0                0 0        0        0                0 0 0
1 2 341 0                0 0        0        0                0 0 0
1 2 342 0                0 0        0        0                0 0 0
1 2 343 0                0 0        0        0                0 0 0
1 2 344 0                0 0        0        80               0 0 0
1 2 F11 0                0 0        0        0                0 0 0
1 2 F12 0                0 0        0        0                0 0 0
1 2 F13 0                0 0        0        0                0 0 0
1 2 F14 0                0 0        0        0                0 0 0
// mcycle counts from reset, then from a written value
1 2 B00 0                0 0        0        E                0 0 0
0 2 000 0                0 0        0        0                0 0 0
0 2 000 0                0 0        0        0                0 0 0
1 2 B00 0                0 0        0        11               0 0 0
1 1 B00 1000             0 0        0        12               0 0 0
1 2 B00 0                0 0        0        1000             0 0 0
0 2 000 0                0 0        0        0                0 0 0
0 2 000 0                0 0        0        0                0 0 0
1 2 B00 0                0 0        0        1003             0 0 0
// mscratch and mtvec ops
1 1 340 A5A5000012345678 0 0        0        0                0 0 0
1 2 340 FF               0 0        0        A5A5000012345678 0 0 0
1 3 340 A5A5000000000000 0 0        0        A5A50000123456FF 0 0 0
1 2 340 0                0 0        0        123456FF         0 0 0
1 3 340 0                0 0        0        123456FF         0 0 0
1 1 305 80001003         0 0        0        0                0 0 0
1 3 305 1                0 0        0        80001003         0 0 0
1 2 305 0                0 0        0        80001002         0 0 0
// Illegal accesses
1 1 7C0 1234             0 0        0        0                1 0 0
1 1 F14 DEAD             0 0        0        0                1 0 0
1 2 F14 0                0 0        0        0                0 0 0
1 2 301 0                0 0        0        8000000000000100 0 0 0
1 2 340 0                0 0        0        123456FF         0 0 0
// Trap entry
1 1 300 8                0 0        0        1888             0 0 0
1 2 300 0                0 0        0        8                0 0 0
2 2 000 0                B 80000124 0        0                0 1 80001000
1 2 341 0                0 0        0        80000124         0 0 0
1 2 342 0                0 0        0        B                0 0 0
1 2 343 0                0 0        0        0                0 0 0
1 2 300 0                0 0        0        1880             0 0 0
// Exception wins over a CSR write in the same cycle
3 1 340 1111             4 80000200 80000203 123456FF         0 1 80001000
1 2 340 0                0 0        0        123456FF         0 0 0
1 2 341 0                0 0        0        80000200         0 0 0
1 2 342 0                0 0        0        4                0 0 0
1 2 343 0                0 0        0        80000203         0 0 0
1 2 300 0                0 0        0        1800             0 0 0
// MRET
1 1 300 80               0 0        0        1800             0 0 0
4 2 000 0                0 0        0        0                0 1 80000200
1 2 300 0                0 0        0        1888             0 0 0
1 1 340 0                0 0        0        123456FF         0 0 0
F 0 000 0                0 0        0        0                0 0 0

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_csr_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sources.f ====
+incdir+hw
hw/csr_pkg.sv
hw/trap_if.sv
hw/csr_op_unit.sv
hw/csr_regfile.sv
hw/trap_unit.sv
hw/csr_top.sv
verif/tb_csr_top.sv
